// File: alu_defines.svh
// ALU coprocessor register map
// bus address width, register offsets on the Wishbone port and the
// position of the carry-chain request bit in the operation word

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

////////////////////
// bus
`define ALU_ADDR_W        3                    // 8 byte-wide locations

////////////////////
// register offsets
`define ALU_REG_A         `ALU_ADDR_W'(0)      // operand a, r/w
`define ALU_REG_B         `ALU_ADDR_W'(1)      // operand b, r/w
`define ALU_REG_OP        `ALU_ADDR_W'(2)      // operation word, write runs it
`define ALU_REG_RESULT    `ALU_ADDR_W'(3)      // latched result, ro
`define ALU_REG_FLAGS     `ALU_ADDR_W'(4)      // latched flags, active high, ro

`define ALU_OP_CARRY_BIT  5                    // op word bit asking for carry chain

`endif

// File: alu_pkg.sv
// ALU coprocessor types
// opcode list in ROM order, the eight-flag word and the execute request
// passed from the bus slave to the status block
`default_nettype none

package alu_pkg;

    ////////////////////
    // opcodes, 5 bits, all 32 codes used
    typedef enum logic [4:0] {
        op_zero,                 // 0
        op_a,
        op_b,
        op_negate_a,
        op_negate_b,
        op_ba_div_10,
        op_ba_mod_10,
        op_b_plus_1,
        op_b_minus_1,            // 8
        op_a_plus_b,
        op_a_minus_b,
        op_b_minus_a,
        op_a_minus_b_signedmag,
        op_a_plus_b_plus_1,      // only reached through carry remap normally
        op_a_minus_b_minus_1,
        op_b_minus_a_minus_1,
        op_a_times_b_hi,         // 16
        op_a_times_b_lo,
        op_a_div_b,
        op_a_mod_b,
        op_a_lsl_b,
        op_a_lsr_b,
        op_a_asr_b,
        op_a_rlc_b,
        op_a_rrc_b,              // 24
        op_a_or_b,
        op_a_and_b,
        op_a_xor_b,
        op_a_nand_b,
        op_not_b,
        op_a_plus_b_bcd,
        op_a_minus_b_bcd
    } alu_op_e;

    // flag word, msb first; polarity depends on who drives it
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic overflow;
        logic gt;
        logic lt;
        logic eq;
        logic ne;
    } alu_flags_t;

    // execute request, 22 bits
    typedef struct packed {
        alu_op_e    op;
        logic       use_carry;   // apply stored carry to +/- ops
        logic [7:0] a;
        logic [7:0] b;
    } alu_req_t;

endpackage

`default_nettype wire

// File: alu_core.sv
// ALU core
// combinational 8-bit ALU, same function as the ROM model: 32 ops,
// result plus eight active-low flags. works on a 10-bit buffer laid out
// as carry : result[7:0] : low carry, so shifts can push bits into either
// carry position
`default_nettype none

module alu_core (
    input  wire alu_pkg::alu_op_e     op,
    input  wire [7:0]                 a,
    input  wire [7:0]                 b,
    output logic [7:0]                result,
    output alu_pkg::alu_flags_t       flags_n
);
    import alu_pkg::*;

    logic [9:0]  cbuf;          // {carry, result, low carry}
    logic [9:0]  asr_buf;       // sign-extended shift of a
    logic [15:0] prod;          // a * b
    logic [15:0] ba_div;        // {b,a} / 10
    logic [15:0] ba_mod;        // {b,a} % 10
    logic [15:0] rot_l;         // {a,a} rotated left, top byte used
    logic [15:0] rot_r;         // {a,a} rotated right, low byte used
    logic [8:0]  bcd_sum;       // decimal a + b, 0..198 for valid bcd
    logic [7:0]  bcd_dif;       // decimal a + (100 - b), borrow when < 100
    logic        ov;            // overflow, active high here
    logic        signed_cmp;    // gt/lt on signed operands
    logic        force_pos;     // negative flag not taken from bit 7
    logic        force_neg;     // negative flag forced on
    alu_flags_t  fl;            // active-high flags before inversion

    // signed overflow for l + r giving sign o
    function automatic logic add_ov(input logic l, input logic r, input logic o);
        return (l == r) && (o != l);    // like signs in, other sign out
    endfunction

    // signed overflow for l - r giving sign o
    function automatic logic sub_ov(input logic l, input logic r, input logic o);
        return (l != r) && (o != l);    // pos - neg = neg, neg - pos = pos
    endfunction

    // two bcd digits to binary
    function automatic logic [7:0] bcd_to_bin(input logic [7:0] v);
        return 8'(v[7:4] * 4'd10) + 8'(v[3:0]);
    endfunction

    // binary 0..99 to two bcd digits
    function automatic logic [7:0] bin_to_bcd(input logic [7:0] v);
        logic [7:0] tens;
        logic [7:0] ones;
        tens = v / 8'd10;
        ones = v % 8'd10;
        return {tens[3:0], ones[3:0]};
    endfunction

    ////////////////////
    // shared datapath pieces
    assign prod    = 16'(a) * 16'(b);
    assign ba_div  = {b, a} / 16'd10;
    assign ba_mod  = {b, a} % 16'd10;
    assign asr_buf = $signed({a[7], a, 1'b0}) >>> b;   // sign fills from the left
    assign rot_l   = {a, a} << b[2:0];                 // count taken mod 8
    assign rot_r   = {a, a} >> b[2:0];
    assign bcd_sum = 9'(bcd_to_bin(a)) + 9'(bcd_to_bin(b));
    assign bcd_dif = bcd_to_bin(a) + (8'd100 - bcd_to_bin(b));  // add with roll over

    ////////////////////
    // op decode
    always_comb begin
        cbuf       = '0;
        ov         = 1'b0;
        signed_cmp = 1'b0;
        force_pos  = 1'b0;
        force_neg  = 1'b0;

        case (op)
            op_zero: cbuf = '0;
            op_a:    cbuf = {1'b0, a, 1'b0};   // pass, carry not consumed
            op_b:    cbuf = {1'b0, b, 1'b0};
            op_negate_a: begin
                cbuf = {1'b0, 8'd0 - a, 1'b0};
                ov   = (a == 8'h80);           // -128 has no positive twin
            end
            op_negate_b: begin
                cbuf = {1'b0, 8'd0 - b, 1'b0};
                ov   = (b == 8'h80);
            end
            op_ba_div_10: begin
                if (b >= 8'd10) ov = 1'b1;    // quotient would not fit a byte
                else cbuf = {1'b0, ba_div[7:0], 1'b0};
            end
            op_ba_mod_10: begin
                if (b >= 8'd10) ov = 1'b1;
                else cbuf = {1'b0, ba_mod[7:0], 1'b0};
            end
            op_b_plus_1: begin
                cbuf = {{1'b0, b} + 9'd1, 1'b0};
                ov   = add_ov(b[7], 1'b0, cbuf[8]);
            end
            op_b_minus_1: begin
                cbuf = {{1'b0, b} - 9'd1, 1'b0};   // borrow lands in carry
                ov   = sub_ov(b[7], 1'b0, cbuf[8]);
            end
            op_a_plus_b: begin
                cbuf = {{1'b0, a} + {1'b0, b}, 1'b0};
                ov   = add_ov(a[7], b[7], cbuf[8]);
            end
            op_a_minus_b: begin
                cbuf = {{1'b0, a} - {1'b0, b}, 1'b0};
                ov   = sub_ov(a[7], b[7], cbuf[8]);
            end
            op_b_minus_a: begin
                cbuf = {{1'b0, b} - {1'b0, a}, 1'b0};
                ov   = sub_ov(b[7], a[7], cbuf[8]);
            end
            op_a_minus_b_signedmag: begin
                cbuf       = {{1'b0, a} - {1'b0, b}, 1'b0};
                ov         = sub_ov(a[7], b[7], cbuf[8]);
                signed_cmp = 1'b1;                 // gt/lt treat operands as signed
            end
            op_a_plus_b_plus_1: begin
                cbuf = {{1'b0, a} + {1'b0, b} + 9'd1, 1'b0};
                ov   = add_ov(a[7], b[7], cbuf[8]);
            end
            op_a_minus_b_minus_1: begin
                cbuf = {{1'b0, a} - {1'b0, b} - 9'd1, 1'b0};
                ov   = sub_ov(a[7], b[7], cbuf[8]);
            end
            op_b_minus_a_minus_1: begin
                cbuf = {{1'b0, b} - {1'b0, a} - 9'd1, 1'b0};
                ov   = sub_ov(b[7], a[7], cbuf[8]);
            end
            op_a_times_b_hi: cbuf = {1'b0, prod[15:8], 1'b0};
            op_a_times_b_lo: cbuf = {prod[15:8] != 8'd0, prod[7:0], 1'b0};  // c = high part
            op_a_div_b: begin
                if (b == 8'd0) begin
                    cbuf = {1'b1, 8'd0, 1'b0};     // div by zero, 0 with c and o
                    ov   = 1'b1;
                end else begin
                    cbuf = {1'b0, a / b, 1'b0};
                end
            end
            op_a_mod_b: begin
                if (b == 8'd0) begin
                    cbuf = {1'b1, 8'd0, 1'b0};
                    ov   = 1'b1;
                end else begin
                    cbuf = {1'b0, a % b, 1'b0};
                end
            end
            op_a_lsl_b: begin                      // c <- a <- 0
                cbuf = {1'b0, a, 1'b0} << b;
                ov   = (a[7] != cbuf[8]);
            end
            op_a_lsr_b: begin                      // 0 -> a -> c
                cbuf    = {1'b0, a, 1'b0} >> b;
                cbuf[9] = cbuf[0];                 // bit out on the right becomes carry
                ov      = (a[7] != cbuf[8]);
            end
            op_a_asr_b:  cbuf = {asr_buf[0], asr_buf[8:1], asr_buf[0]};
            op_a_rlc_b: begin                      // last bit wrapped goes to carry
                cbuf = {(b != 8'd0) & rot_l[8], rot_l[15:8], 1'b0};
                ov   = (a[7] != rot_l[15]);
            end
            op_a_rrc_b: begin
                cbuf = {(b != 8'd0) & rot_r[7], rot_r[7:0], 1'b0};
                ov   = (a[7] != rot_r[7]);
            end
            op_a_or_b:   cbuf = {1'b0, a | b, 1'b0};
            op_a_and_b:  cbuf = {1'b0, a & b, 1'b0};
            op_a_xor_b:  cbuf = {1'b0, a ^ b, 1'b0};
            op_a_nand_b: cbuf = {1'b0, ~(a & b), 1'b0};
            op_not_b:    cbuf = {1'b0, ~b, 1'b0};
            op_a_plus_b_bcd: begin                 // no carry in
                force_pos = 1'b1;
                cbuf = {bcd_sum >= 9'd100, bin_to_bcd(8'(bcd_sum % 9'd100)), 1'b0};
            end
            op_a_minus_b_bcd: begin
                force_pos = 1'b1;                  // decimal sign, not bit 7
                force_neg = (b > a);
                cbuf = {bcd_dif < 8'd100, bin_to_bcd(bcd_dif % 8'd100), 1'b0};  // c = borrow
            end
        endcase
    end

    ////////////////////
    // flags, inverted on the way out
    assign result = cbuf[8:1];

    always_comb begin
        fl.carry    = cbuf[9];
        fl.zero     = (cbuf[8:1] == 8'd0);
        fl.negative = force_neg || (!force_pos && cbuf[8]);
        fl.overflow = ov;
        fl.gt       = signed_cmp ? ($signed(a) > $signed(b)) : (a > b);
        fl.lt       = signed_cmp ? ($signed(a) < $signed(b)) : (a < b);
        fl.eq       = (a == b);                    // operands, not result
        fl.ne       = (a != b);
        flags_n     = alu_flags_t'(~fl);
    end

endmodule

`default_nettype wire

// File: alu_status.sv
// ALU status block
// remaps +/- ops to their carry forms when a chain is asked for and the
// stored carry is set, feeds the core, and latches result and flags
// (active high) when an operation executes
`default_nettype none

module alu_status (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       exec,          // one-cycle run strobe
    input  wire alu_pkg::alu_req_t    req,
    output alu_pkg::alu_op_e          core_op,
    output logic [7:0]                core_a,
    output logic [7:0]                core_b,
    input  wire [7:0]                 core_result,
    input  wire alu_pkg::alu_flags_t  core_flags_n,  // active low from core
    output logic [7:0]                result,
    output alu_pkg::alu_flags_t       flags
);
    import alu_pkg::*;

    logic chain_c;    // carry kept for multi-byte chains

    assign chain_c = flags.carry;   // latched carry of the last op

    ////////////////////
    // carry-chain remap
    always_comb begin
        core_op = req.op;
        if (req.use_carry && chain_c) begin
            case (req.op)
                op_a_plus_b:  core_op = op_a_plus_b_plus_1;
                op_a_minus_b: core_op = op_a_minus_b_minus_1;   // borrow in
                op_b_minus_a: core_op = op_b_minus_a_minus_1;
                default:      core_op = req.op;
            endcase
        end
    end

    assign core_a = req.a;
    assign core_b = req.b;

    ////////////////////
    // result and flag registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
            flags  <= '0;
        end else if (exec) begin
            result <= core_result;
            flags  <= alu_flags_t'(~core_flags_n);   // store active high
        end
    end

endmodule

`default_nettype wire

// File: alu_wb_regs.sv
// ALU Wishbone slave
// classic single-cycle slave, 8-bit data. holds operands and the last
// operation word, raises a registered ack one cycle after cyc & stb,
// and pulses exec in that first cycle of an OP write
`default_nettype none
`include "alu_defines.svh"

module alu_wb_regs (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cyc,
    input  wire                       stb,
    input  wire                       we,
    input  wire [`ALU_ADDR_W-1:0]     adr,
    input  wire [7:0]                 dat_w,
    output logic [7:0]                dat_r,
    output logic                      ack,
    output logic                      exec,
    output alu_pkg::alu_req_t         req,
    input  wire [7:0]                 result,
    input  wire alu_pkg::alu_flags_t  flags
);
    import alu_pkg::*;

    logic [7:0] reg_a;       // operand a
    logic [7:0] reg_b;       // operand b
    alu_op_e    op_q;        // last opcode written
    logic       carry_q;     // last carry-chain request
    logic       access;      // first cycle of a bus cycle
    logic       wr;

    assign access = cyc & stb & ~ack;
    assign wr     = access & we;

    ////////////////////
    // handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) ack <= 1'b0;
        else        ack <= access;     // high for one cycle only
    end

    // run strobe, same cycle the op word is captured
    assign exec = wr && (adr == `ALU_REG_OP);

    // op comes straight off the bus, operands from the registers
    always_comb begin
        req.op        = alu_op_e'(dat_w[4:0]);
        req.use_carry = dat_w[`ALU_OP_CARRY_BIT];
        req.a         = reg_a;
        req.b         = reg_b;
    end

    ////////////////////
    // writable registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a   <= '0;
            reg_b   <= '0;
            op_q    <= op_zero;
            carry_q <= 1'b0;
        end else if (wr) begin
            case (adr)
                `ALU_REG_A:  reg_a <= dat_w;
                `ALU_REG_B:  reg_b <= dat_w;
                `ALU_REG_OP: begin
                    op_q    <= req.op;
                    carry_q <= req.use_carry;
                end
                default: ;                     // result/flags are read only
            endcase
        end
    end

    ////////////////////
    // read mux, adr is held through ack
    always_comb begin
        dat_r = 8'd0;                          // 5..7 read zero
        case (adr)
            `ALU_REG_A:      dat_r = reg_a;
            `ALU_REG_B:      dat_r = reg_b;
            `ALU_REG_OP: begin
                dat_r = 8'(op_q);
                dat_r[`ALU_OP_CARRY_BIT] = carry_q;
            end
            `ALU_REG_RESULT: dat_r = result;
            `ALU_REG_FLAGS:  dat_r = flags;    // active high
            default:         dat_r = 8'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: alu_top.sv
// ALU coprocessor top
// Wishbone slave in front of the status block and the combinational
// core. an OP write updates RESULT and FLAGS on the edge that raises ack
`default_nettype none
`include "alu_defines.svh"

module alu_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cyc,
    input  wire                    stb,
    input  wire                    we,
    input  wire [`ALU_ADDR_W-1:0]  adr,
    input  wire [7:0]              dat_w,
    output logic [7:0]             dat_r,
    output logic                   ack
);
    import alu_pkg::*;

    logic       exec;           // run strobe from bus slave
    alu_req_t   req;            // op word + operands
    alu_op_e    core_op;        // after carry remap
    logic [7:0] core_a;
    logic [7:0] core_b;
    logic [7:0] core_result;
    alu_flags_t core_flags_n;   // active low
    logic [7:0] result;         // latched
    alu_flags_t flags;          // latched, active high

    ////////////////////
    // bus slave
    alu_wb_regs i_alu_wb_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack),
        .exec   (exec),
        .req    (req),
        .result (result),
        .flags  (flags)
    );

    alu_status i_alu_status (
        .clk          (clk),
        .rst_n        (rst_n),
        .exec         (exec),
        .req          (req),
        .core_op      (core_op),
        .core_a       (core_a),
        .core_b       (core_b),
        .core_result  (core_result),
        .core_flags_n (core_flags_n),
        .result       (result),
        .flags        (flags)
    );

    // combinational, settles within the exec cycle
    alu_core i_alu_core (
        .op      (core_op),
        .a       (core_a),
        .b       (core_b),
        .result  (core_result),
        .flags_n (core_flags_n)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
// testbench clock and reset
// 40-unit clock, rst_n held low for the first 4 rising edges
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial clk = 1'b0;
    always #20 clk = ~clk;      // period 40

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;        // release just after the 4th edge
    end

endmodule

`default_nettype wire

// File: alu_props.sv
// bus handshake properties
// checks the registered ack and the exec to ack timing of the ALU top
`default_nettype none

module alu_props (
    input wire clk,
    input wire rst_n,
    input wire cyc,
    input wire stb,
    input wire ack,
    input wire exec
);

    // ack is only ever an answer to a request seen the cycle before
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(cyc && stb))
        else $error("ack without a preceding cyc and stb");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("ack held for two cycles");

    // result lands on the same edge that raises ack
    exec_then_ack: assert property (@(posedge clk) disable iff (!rst_n)
        exec |=> ack)
        else $error("exec not followed by ack");

endmodule

bind alu_top alu_props i_alu_props (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack),
    .exec  (exec)
);

`default_nettype wire

// File: alu_tb.sv
// ALU coprocessor testbench
// directed tests over the Wishbone port: reset values, add/sub, carry
// chains, mul/div, shifts and logic, BCD. expected values come from a
// behavioral model of the op rules below
`default_nettype none
`include "alu_defines.svh"

module alu_tb;
    import alu_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`ALU_ADDR_W-1:0] adr;
    logic [7:0]             dat_w;
    logic [7:0]             dat_r;
    logic                   ack;
    logic [31:0]            rng = 32'ha3cb;   // xorshift state
    logic                   chain_c = 1'b0;   // model of stored carry

    tb_clock i_tb_clock (.clk(clk), .rst_n(rst_n));

    alu_top i_alu_top (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    ////////////////////
    // helpers
    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [7:0] to_bcd(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            fail_now($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_flags(input alu_flags_t got, input alu_flags_t exp);
        if (got !== exp)
            fail_now($sformatf("** Error: flags = %h, expected %h", got, exp));
    endtask

    ////////////////////
    // bus, drive 1 unit after the edge, hold until ack
    task automatic bus_cycle(input logic w, input logic [`ALU_ADDR_W-1:0] a,
                             input logic [7:0] d, output logic [7:0] q);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        dat_w = d;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 20) fail_now("timeout waiting for ack");
        end while (!ack);
        q   = dat_r;                       // valid while ack is high
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`ALU_ADDR_W-1:0] a, input logic [7:0] d);
        logic [7:0] unused;
        bus_cycle(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input logic [`ALU_ADDR_W-1:0] a, output logic [7:0] q);
        bus_cycle(1'b0, a, 8'd0, q);
    endtask

    ////////////////////
    // reference rules
    function automatic alu_flags_t make_flags(input logic c, input logic [7:0] r,
            input logic n, input logic v, input logic sc,
            input logic [7:0] a, input logic [7:0] b);
        alu_flags_t f;
        f.carry    = c;
        f.zero     = (r == 8'd0);
        f.negative = n;
        f.overflow = v;
        f.gt = sc ? ($signed(a) > $signed(b)) : (a > b);
        f.lt = sc ? ($signed(a) < $signed(b)) : (a < b);
        f.eq = (a == b);                   // operands, not result
        f.ne = (a != b);
        return f;
    endfunction

    task automatic expect_op(input alu_op_e op, input logic [7:0] a, input logic [7:0] b,
                             output logic [7:0] r, output alu_flags_t f);
        logic [8:0]  s;
        logic [15:0] ext;
        logic        c, v, sc, n, bcd_n, use_n;
        int          k, j, da, db, dd;
        c     = 0;
        v     = 0;
        sc    = 0;
        use_n = 0;
        bcd_n = 0;
        r     = 0;
        k     = int'(b);
        j     = k % 8;
        da    = a[7:4] * 10 + a[3:0];
        db    = b[7:4] * 10 + b[3:0];
        ext   = {{8{a[7]}}, a};
        case (op)
            op_zero:     r = 0;
            op_a:        r = a;
            op_b:        r = b;
            op_negate_a: begin
                r = -a;
                v = (a == 8'h80);
            end
            op_negate_b: begin
                r = -b;
                v = (b == 8'h80);
            end
            op_ba_div_10, op_ba_mod_10: begin
                if (b >= 10) v = 1;        // quotient overflow
                else r = (op == op_ba_div_10) ? 8'({b, a} / 10) : 8'({b, a} % 10);
            end
            op_b_plus_1: begin
                s = b + 9'd1;
                r = s[7:0];
                c = s[8];
                v = !b[7] && r[7];
            end
            op_b_minus_1: begin
                s = {1'b0, b} - 9'd1;
                r = s[7:0];
                c = s[8];
                v = b[7] && !r[7];
            end
            op_a_plus_b, op_a_plus_b_plus_1: begin
                s = a + b + 9'(op == op_a_plus_b_plus_1);
                r = s[7:0];
                c = s[8];
                v = (a[7] == b[7]) && (r[7] != a[7]);
            end
            op_a_minus_b, op_a_minus_b_minus_1, op_a_minus_b_signedmag: begin
                s = {1'b0, a} - {1'b0, b} - 9'(op == op_a_minus_b_minus_1);
                r = s[7:0];
                c = s[8];                  // borrow
                v = (a[7] != b[7]) && (r[7] != a[7]);
                sc = (op == op_a_minus_b_signedmag);
            end
            op_b_minus_a, op_b_minus_a_minus_1: begin
                s = {1'b0, b} - {1'b0, a} - 9'(op == op_b_minus_a_minus_1);
                r = s[7:0];
                c = s[8];
                v = (b[7] != a[7]) && (r[7] != b[7]);
            end
            op_a_times_b_hi: r = 8'((16'(a) * 16'(b)) >> 8);
            op_a_times_b_lo: begin
                r = 8'(a * b);
                c = ((16'(a) * 16'(b)) >> 8) != 0;
            end
            op_a_div_b, op_a_mod_b: begin
                if (b == 0) begin
                    c = 1;
                    v = 1;
                end
                else r = (op == op_a_div_b) ? a / b : a % b;
            end
            op_a_lsl_b: begin              // carry is the last bit out on the left
                r = (k >= 8) ? 8'd0 : 8'(a << k);
                c = (k >= 1 && k <= 8) ? a[8-k] : 1'b0;
                v = a[7] != r[7];
            end
            op_a_lsr_b: begin
                r = (k >= 8) ? 8'd0 : a >> k;
                c = (k >= 1 && k <= 8) ? a[k-1] : 1'b0;
                v = a[7] != r[7];
            end
            op_a_asr_b: begin
                r = 8'($signed(ext) >>> k);
                c = (k == 0) ? 1'b0 : ext[k-1];
            end
            op_a_rlc_b: begin
                r = (a << j) | (a >> (8 - j));
                c = (k != 0) & r[0];
                v = a[7] != r[7];
            end
            op_a_rrc_b: begin
                r = (a >> j) | (a << (8 - j));
                c = (k != 0) & r[7];
                v = a[7] != r[7];
            end
            op_a_or_b:   r = a | b;
            op_a_and_b:  r = a & b;
            op_a_xor_b:  r = a ^ b;
            op_a_nand_b: r = ~(a & b);
            op_not_b:    r = ~b;
            op_a_plus_b_bcd: begin
                dd = da + db;
                c = dd >= 100;
                r = to_bcd(dd % 100);
                use_n = 1;
                bcd_n = 0;                 // never negative
            end
            op_a_minus_b_bcd: begin
                dd = da - db;
                c = dd < 0;
                r = to_bcd((dd + 100) % 100);
                use_n = 1;
                bcd_n = (b > a);
            end
        endcase
        n = use_n ? bcd_n : r[7];
        f = make_flags(c, r, n, v, sc, a, b);
    endtask

    // write operands and op word, read back and compare
    task automatic run_op(input alu_op_e op, input logic uc, input logic [7:0] a,
                          input logic [7:0] b, output logic [7:0] res);
        alu_op_e    eff;
        logic [7:0] er;
        logic [7:0] d;
        alu_flags_t ef;
        eff = op;
        if (uc && chain_c) begin           // carry-chain remap
            if (op == op_a_plus_b)  eff = op_a_plus_b_plus_1;
            if (op == op_a_minus_b) eff = op_a_minus_b_minus_1;
            if (op == op_b_minus_a) eff = op_b_minus_a_minus_1;
        end
        expect_op(eff, a, b, er, ef);
        wb_write(`ALU_REG_A, a);
        wb_write(`ALU_REG_B, b);
        wb_write(`ALU_REG_OP, {2'b00, uc, op});
        wb_read(`ALU_REG_RESULT, d);
        check_byte("result", d, er);
        res = d;                           // result as read from the DUT
        wb_read(`ALU_REG_FLAGS, d);
        check_flags(alu_flags_t'(d), ef);
        chain_c = ef.carry;
    endtask

    ////////////////////
    // tests
    task automatic reset_and_readback();
        logic [7:0] d;
        wb_read(`ALU_REG_RESULT, d);
        check_byte("result", d, 8'h00);
        wb_read(`ALU_REG_FLAGS, d);
        check_flags(alu_flags_t'(d), '0);
        wb_read(`ALU_REG_OP, d);
        check_byte("op", d, 8'h00);
        wb_write(`ALU_REG_A, 8'h5a);
        wb_write(`ALU_REG_B, 8'hc3);
        wb_read(`ALU_REG_A, d);
        check_byte("a", d, 8'h5a);
        wb_read(`ALU_REG_B, d);
        check_byte("b", d, 8'hc3);
        for (int i = 5; i < 8; i++) begin
            wb_read(`ALU_ADDR_W'(i), d);
            check_byte("unused", d, 8'h00);
        end
    endtask

    task automatic add_and_subtract();
        alu_op_e ops [10] = '{op_a_plus_b, op_a_minus_b, op_b_minus_a, op_a_minus_b_signedmag,
            op_a_plus_b_plus_1, op_a_minus_b_minus_1, op_b_minus_a_minus_1,
            op_b_plus_1, op_b_minus_1, op_a_minus_b};
        logic [7:0] a, b, r;
        for (int i = 0; i < 40; i++) begin
            a = 8'(xorshift());
            b = (i % 8 == 0) ? a : 8'(xorshift());   // some equal pairs
            run_op(ops[i % 10], 1'b0, a, b, r);
        end
        run_op(op_b_minus_1, 1'b0, 8'h00, 8'h00, r);  // borrow and wrap
    endtask

    task automatic carry_chain();
        logic [15:0] x, y, sum;
        logic [7:0]  lo, hi, d;
        for (int i = 0; i < 12; i++) begin
            x   = 16'(xorshift());
            y   = 16'(xorshift());
            sum = x + y;
            run_op(op_a_plus_b, 1'b0, x[7:0], y[7:0], lo);
            run_op(op_a_plus_b, 1'b1, x[15:8], y[15:8], hi);
            check_byte("sum_hi", hi, sum[15:8]);
            check_byte("sum_lo", lo, sum[7:0]);
        end
        wb_read(`ALU_REG_OP, d);
        check_byte("op", d, {2'b00, 1'b1, op_a_plus_b});
        run_op(op_a_plus_b, 1'b0, 8'hff, 8'h01, d);   // sets carry
        run_op(op_a_plus_b, 1'b0, 8'h10, 8'h20, d);   // carry not used
        check_byte("no_chain", d, 8'h30);
    endtask

    task automatic multiply_divide();
        alu_op_e    ops [4] = '{op_a_times_b_hi, op_a_times_b_lo, op_a_div_b, op_a_mod_b};
        logic [7:0] r;
        for (int i = 0; i < 24; i++)
            run_op(ops[i % 4], 1'b0, 8'(xorshift()), (i % 6 == 5) ? 8'd0 : 8'(xorshift()), r);
        run_op(op_a_div_b, 1'b0, 8'h37, 8'h00, r);
        run_op(op_a_mod_b, 1'b0, 8'h37, 8'h00, r);
        for (int i = 0; i < 12; i++)
            run_op((i % 2) ? op_ba_mod_10 : op_ba_div_10, 1'b0, 8'(xorshift()),
                   8'(xorshift() % 13), r);
    endtask

    task automatic shifts_and_logic();
        alu_op_e    sh [5] = '{op_a_lsl_b, op_a_lsr_b, op_a_asr_b, op_a_rlc_b, op_a_rrc_b};
        alu_op_e    lg [10] = '{op_zero, op_a, op_b, op_negate_a, op_negate_b,
            op_a_or_b, op_a_and_b, op_a_xor_b, op_a_nand_b, op_not_b};
        logic [7:0] a, r;
        for (int k = 0; k < 10; k++) begin
            a = 8'(xorshift());
            for (int s = 0; s < 5; s++) run_op(sh[s], 1'b0, a, 8'(k), r);
        end
        for (int i = 0; i < 20; i++)
            run_op(lg[i % 10], 1'b0, 8'(xorshift()), 8'(xorshift()), r);
        run_op(op_negate_a, 1'b0, 8'h80, 8'h00, r);
    endtask

    task automatic bcd_arithmetic();
        logic [7:0] r;
        for (int i = 0; i < 20; i++)
            run_op((i % 2) ? op_a_minus_b_bcd : op_a_plus_b_bcd, 1'b0,
                   to_bcd(int'(xorshift() % 100)), to_bcd(int'(xorshift() % 100)), r);
    endtask

    ////////////////////
    // main sequence
    initial begin
        int n;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = 8'd0;
        n     = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) fail_now("reset never released");
        end
        reset_and_readback();
        add_and_subtract();
        carry_chain();
        multiply_divide();
        shifts_and_logic();
        bcd_arithmetic();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
alu_pkg.sv
alu_core.sv
alu_status.sv
alu_wb_regs.sv
alu_top.sv
tb_clock.sv
alu_props.sv
alu_tb.sv

// File: Makefile
# Verilator build and run of the ALU coprocessor testbench

SRCS := alu_defines.svh alu_pkg.sv alu_core.sv alu_status.sv alu_wb_regs.sv \
        alu_top.sv tb_clock.sv alu_props.sv alu_tb.sv

.PHONY: run clean

run: obj_dir/Valu_tb
	./obj_dir/Valu_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

obj_dir/Valu_tb: $(SRCS) list.f
	verilator --binary --timing --assert -j 0 --top-module alu_tb -f list.f -o Valu_tb

clean:
	rm -rf obj_dir sim.log
